//--- hdl/fft_pkg.sv
package fft_pkg;

   // transform length
   parameter int fft_points = 64;

   // one real or imaginary component
   parameter int sample_width = 11;

   // twiddle coefficients, unit magnitude is 65535
   parameter int coef_width = 17;

   // rescale after the twiddle product
   parameter int coef_frac = 16;

   // two's complement sample component
   typedef logic signed [sample_width-1:0] sample_t;

   // {real, imag}, real in the upper half
   typedef logic [2*sample_width-1:0] cplx_t;

   // signed coefficient component
   typedef logic signed [coef_width-1:0] coef_t;

   // twiddle index k and exponent m, 0..63
   typedef logic [$clog2(fft_points)-1:0] twiddle_index_t;

endpackage

//--- hdl/butterfly_core.sv
`timescale 1ns/1ps

module butterfly_core (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    valid_i,
   input  fft_pkg::twiddle_index_t k,
   input  fft_pkg::cplx_t          a0,
   input  fft_pkg::cplx_t          a1,
   input  fft_pkg::cplx_t          a2,
   input  fft_pkg::cplx_t          a3,
   output fft_pkg::cplx_t          c0,
   output fft_pkg::cplx_t          c1,
   output fft_pkg::cplx_t          c2,
   output fft_pkg::cplx_t          c3,
   output fft_pkg::twiddle_index_t k_q,
   output logic                    valid_q
);

   localparam int sw = fft_pkg::sample_width;

   // componentwise sum, wraps to sample width
   function automatic fft_pkg::cplx_t cadd(input fft_pkg::cplx_t x, input fft_pkg::cplx_t y);
      fft_pkg::sample_t re;
      fft_pkg::sample_t im;
      re = x[2*sw-1 -: sw] + y[2*sw-1 -: sw];
      im = x[sw-1:0] + y[sw-1:0];
      return {re, im};
   endfunction

   function automatic fft_pkg::cplx_t csub(input fft_pkg::cplx_t x, input fft_pkg::cplx_t y);
      fft_pkg::sample_t re;
      fft_pkg::sample_t im;
      re = x[2*sw-1 -: sw] - y[2*sw-1 -: sw];
      im = x[sw-1:0] - y[sw-1:0];
      return {re, im};
   endfunction

   // quarter turn: re <- -im, im <- re
   function automatic fft_pkg::cplx_t rotate(input fft_pkg::cplx_t x);
      fft_pkg::sample_t re;
      fft_pkg::sample_t im;
      re = -x[sw-1:0];
      im = x[2*sw-1 -: sw];
      return {re, im};
   endfunction

   fft_pkg::cplx_t b0;
   fft_pkg::cplx_t b1;
   fft_pkg::cplx_t b2;
   fft_pkg::cplx_t b3;
   fft_pkg::cplx_t b3_rot;

   assign b0     = cadd(a0, a2);
   assign b1     = cadd(a1, a3);
   assign b2     = csub(a0, a2);
   assign b3     = csub(a1, a3);
   assign b3_rot = rotate(b3);

   // second adder rank straight into the pipeline register
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         c0      <= '0;
         c1      <= '0;
         c2      <= '0;
         c3      <= '0;
         k_q     <= '0;
         valid_q <= 1'b0;
      end else begin
         c0      <= cadd(b0, b1);
         c1      <= csub(b2, b3_rot);
         c2      <= csub(b0, b1);
         c3      <= cadd(b2, b3_rot);
         k_q     <= k;
         valid_q <= valid_i;
      end
   end

endmodule

//--- hdl/twiddle_rom.sv
`timescale 1ns/1ps

module twiddle_rom #(
   parameter int harmonic = 1
) (
   input  fft_pkg::twiddle_index_t k,
   output fft_pkg::coef_t          wr,
   output fft_pkg::coef_t          wi
);

   localparam int quarter = fft_pkg::fft_points / 4;
   localparam int off_w   = $clog2(quarter);

   // round(65535 * cos(2*pi*i/64)), i = 0..16
   function automatic fft_pkg::coef_t cos_quarter(input logic [off_w:0] i);
      fft_pkg::coef_t v;
      case (i)
         5'd0:    v = 17'sd65535;
         5'd1:    v = 17'sd65219;
         5'd2:    v = 17'sd64276;
         5'd3:    v = 17'sd62713;
         5'd4:    v = 17'sd60546;
         5'd5:    v = 17'sd57797;
         5'd6:    v = 17'sd54490;
         5'd7:    v = 17'sd50659;
         5'd8:    v = 17'sd46340;
         5'd9:    v = 17'sd41575;
         5'd10:   v = 17'sd36409;
         5'd11:   v = 17'sd30893;
         5'd12:   v = 17'sd25079;
         5'd13:   v = 17'sd19024;
         5'd14:   v = 17'sd12785;
         5'd15:   v = 17'sd6424;
         default: v = 17'sd0;
      endcase
      return v;
   endfunction

   fft_pkg::twiddle_index_t m;
   logic [1:0]              quad;
   logic [off_w-1:0]        off;
   logic [off_w:0]          off_mirror;
   fft_pkg::coef_t          cos_a;
   fft_pkg::coef_t          cos_b;

   // exponent m = h*k mod 64
   assign m = fft_pkg::twiddle_index_t'((harmonic * k) % fft_pkg::fft_points);

   assign quad       = m[off_w +: 2];
   assign off        = m[off_w-1:0];
   assign off_mirror = (off_w + 1)'(quarter) - {1'b0, off};

   // cos of the offset, and cos of the mirrored offset (= sin of the offset)
   assign cos_a = cos_quarter({1'b0, off});
   assign cos_b = cos_quarter(off_mirror);

   // quadrant fold, wi is -sin
   always_comb begin
      case (quad)
         2'd0: begin
            wr = cos_a;
            wi = -cos_b;
         end
         2'd1: begin
            wr = -cos_b;
            wi = -cos_a;
         end
         2'd2: begin
            wr = -cos_a;
            wi = cos_b;
         end
         default: begin
            wr = cos_b;
            wi = cos_a;
         end
      endcase
   end

endmodule

//--- hdl/twiddle_multiplier.sv
`timescale 1ns/1ps

module twiddle_multiplier (
   input  logic           clk,
   input  logic           rst,
   input  fft_pkg::cplx_t c,
   input  fft_pkg::coef_t wr,
   input  fft_pkg::coef_t wi,
   output fft_pkg::cplx_t y
);

   localparam int sw = fft_pkg::sample_width;
   // product plus one bit for the sum of two products
   localparam int pw = fft_pkg::sample_width + fft_pkg::coef_width + 1;

   fft_pkg::sample_t     cr;
   fft_pkg::sample_t     ci;
   logic signed [pw-1:0] prod_r;
   logic signed [pw-1:0] prod_i;
   logic signed [pw-1:0] scaled_r;
   logic signed [pw-1:0] scaled_i;

   assign cr = c[2*sw-1 -: sw];
   assign ci = c[sw-1:0];

   // full precision complex product
   assign prod_r = cr * wr - ci * wi;
   assign prod_i = cr * wi + ci * wr;

   // floor rescale
   assign scaled_r = prod_r >>> fft_pkg::coef_frac;
   assign scaled_i = prod_i >>> fft_pkg::coef_frac;

   // low bits only, wraps like the adder network
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         y <= '0;
      end else begin
         y <= {scaled_r[sw-1:0], scaled_i[sw-1:0]};
      end
   end

endmodule

//--- hdl/twiddle_stage.sv
`timescale 1ns/1ps

module twiddle_stage (
   input  logic                    clk,
   input  logic                    rst,
   input  fft_pkg::cplx_t          c0,
   input  fft_pkg::cplx_t          c1,
   input  fft_pkg::cplx_t          c2,
   input  fft_pkg::cplx_t          c3,
   input  fft_pkg::twiddle_index_t k,
   input  logic                    valid,
   output fft_pkg::cplx_t          y0,
   output fft_pkg::cplx_t          y1,
   output fft_pkg::cplx_t          y2,
   output fft_pkg::cplx_t          y3,
   output logic                    valid_o
);

   fft_pkg::coef_t w1r;
   fft_pkg::coef_t w1i;
   fft_pkg::coef_t w2r;
   fft_pkg::coef_t w2i;
   fft_pkg::coef_t w3r;
   fft_pkg::coef_t w3i;

   // W^k
   twiddle_rom #(.harmonic(1)) u_rom1 (
      .k  (k),
      .wr (w1r),
      .wi (w1i)
   );

   twiddle_multiplier u_mul1 (
      .clk (clk),
      .rst (rst),
      .c   (c1),
      .wr  (w1r),
      .wi  (w1i),
      .y   (y1)
   );

   // W^2k
   twiddle_rom #(.harmonic(2)) u_rom2 (
      .k  (k),
      .wr (w2r),
      .wi (w2i)
   );

   twiddle_multiplier u_mul2 (
      .clk (clk),
      .rst (rst),
      .c   (c2),
      .wr  (w2r),
      .wi  (w2i),
      .y   (y2)
   );

   // W^3k
   twiddle_rom #(.harmonic(3)) u_rom3 (
      .k  (k),
      .wr (w3r),
      .wi (w3i)
   );

   twiddle_multiplier u_mul3 (
      .clk (clk),
      .rst (rst),
      .c   (c3),
      .wr  (w3r),
      .wi  (w3i),
      .y   (y3)
   );

   // c0 needs no twiddle, just match the multiplier latency
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         y0      <= '0;
         valid_o <= 1'b0;
      end else begin
         y0      <= c0;
         valid_o <= valid;
      end
   end

endmodule

//--- hdl/radix4_butterfly.sv
`timescale 1ns/1ps

module radix4_butterfly (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    valid_i,
   input  fft_pkg::twiddle_index_t k,
   input  fft_pkg::cplx_t          a0,
   input  fft_pkg::cplx_t          a1,
   input  fft_pkg::cplx_t          a2,
   input  fft_pkg::cplx_t          a3,
   output fft_pkg::cplx_t          y0,
   output fft_pkg::cplx_t          y1,
   output fft_pkg::cplx_t          y2,
   output fft_pkg::cplx_t          y3,
   output logic                    valid_o
);

   // first stage outputs
   fft_pkg::cplx_t          c0;
   fft_pkg::cplx_t          c1;
   fft_pkg::cplx_t          c2;
   fft_pkg::cplx_t          c3;
   fft_pkg::twiddle_index_t k_q;
   logic                    valid_q;

   butterfly_core u_core (
      .clk     (clk),
      .rst     (rst),
      .valid_i (valid_i),
      .k       (k),
      .a0      (a0),
      .a1      (a1),
      .a2      (a2),
      .a3      (a3),
      .c0      (c0),
      .c1      (c1),
      .c2      (c2),
      .c3      (c3),
      .k_q     (k_q),
      .valid_q (valid_q)
   );

   twiddle_stage u_twiddle (
      .clk     (clk),
      .rst     (rst),
      .c0      (c0),
      .c1      (c1),
      .c2      (c2),
      .c3      (c3),
      .k       (k_q),
      .valid   (valid_q),
      .y0      (y0),
      .y1      (y1),
      .y2      (y2),
      .y3      (y3),
      .valid_o (valid_o)
   );

endmodule

//--- verification/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
   parameter int period       = 8,
   parameter int reset_cycles = 4
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   // release just after an edge
   initial begin
      rst = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      #1 rst = 1'b1;
   end

endmodule

//--- verification/butterfly_checker.sv
`timescale 1ns/1ps

module butterfly_checker (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    valid_i,
   input  fft_pkg::twiddle_index_t k,
   input  fft_pkg::cplx_t          a0,
   input  fft_pkg::cplx_t          a1,
   input  fft_pkg::cplx_t          a2,
   input  fft_pkg::cplx_t          a3,
   input  fft_pkg::cplx_t          y0,
   input  fft_pkg::cplx_t          y1,
   input  fft_pkg::cplx_t          y2,
   input  fft_pkg::cplx_t          y3,
   input  logic                    valid_o,
   output int                      error_count,
   output int                      check_count,
   output int                      outstanding
);

   localparam int  sw = 11;
   localparam real pi = 3.14159265358979323846;

   logic [8*sw-1:0] expected_q[$];
   logic [1:0]      valid_hist;

   initial begin
      error_count = 0;
      check_count = 0;
      outstanding = 0;
      valid_hist  = '0;
   end

   function automatic int wrap(input longint x);
      longint r;
      r = x & 2047;
      if (r >= 1024) begin
         r -= 2048;
      end
      return int'(r);
   endfunction

   function automatic int re_of(input fft_pkg::cplx_t x);
      return int'($signed(x[2*sw-1 -: sw]));
   endfunction

   function automatic int im_of(input fft_pkg::cplx_t x);
      return int'($signed(x[sw-1:0]));
   endfunction

   function automatic fft_pkg::cplx_t pack(input int re, input int im);
      logic [sw-1:0] re_bits;
      logic [sw-1:0] im_bits;
      re_bits = re[sw-1:0];
      im_bits = im[sw-1:0];
      return {re_bits, im_bits};
   endfunction

   // stored coefficients are rounded to nearest
   function automatic longint coefficient(input int m, input bit imag_part);
      real theta;
      theta = 2.0 * pi * m / 64.0;
      if (imag_part) begin
         return longint'(-65535.0 * $sin(theta));
      end else begin
         return longint'(65535.0 * $cos(theta));
      end
   endfunction

   function automatic fft_pkg::cplx_t apply_twiddle(input fft_pkg::cplx_t c, input int h,
                                                    input int kk);
      longint wr;
      longint wi;
      longint pr;
      longint pim;
      int     m;
      m   = (h * kk) % 64;
      wr  = coefficient(m, 1'b0);
      wi  = coefficient(m, 1'b1);
      pr  = re_of(c) * wr - im_of(c) * wi;
      pim = re_of(c) * wi + im_of(c) * wr;
      // floor divide by 2^16
      return pack(wrap(pr >>> 16), wrap(pim >>> 16));
   endfunction

   function automatic logic [8*sw-1:0] expected_outputs(input fft_pkg::twiddle_index_t kk,
      input fft_pkg::cplx_t x0, input fft_pkg::cplx_t x1,
      input fft_pkg::cplx_t x2, input fft_pkg::cplx_t x3);
      int b0r, b0i;
      int b1r, b1i;
      int b2r, b2i;
      int b3r, b3i;
      int jr, ji;
      fft_pkg::cplx_t c0, c1, c2, c3;
      b0r = wrap(re_of(x0) + re_of(x2));
      b0i = wrap(im_of(x0) + im_of(x2));
      b1r = wrap(re_of(x1) + re_of(x3));
      b1i = wrap(im_of(x1) + im_of(x3));
      b2r = wrap(re_of(x0) - re_of(x2));
      b2i = wrap(im_of(x0) - im_of(x2));
      b3r = wrap(re_of(x1) - re_of(x3));
      b3i = wrap(im_of(x1) - im_of(x3));
      // quarter turn of b3
      jr = wrap(-b3i);
      ji = b3r;
      c0 = pack(b0r + b1r, b0i + b1i);
      c1 = pack(b2r - jr, b2i - ji);
      c2 = pack(b0r - b1r, b0i - b1i);
      c3 = pack(b2r + jr, b2i + ji);
      return {c0, apply_twiddle(c1, 1, kk), apply_twiddle(c2, 2, kk),
              apply_twiddle(c3, 3, kk)};
   endfunction

   task automatic compare_leg(input string name, input fft_pkg::cplx_t expected,
                              input fft_pkg::cplx_t actual);
      if (actual !== expected) begin
         $display("[ERROR] %0t ns: %s expected %h (%0d, %0d) actual %h (%0d, %0d)",
                  $time, name, expected, re_of(expected), im_of(expected),
                  actual, re_of(actual), im_of(actual));
         error_count++;
      end
   endtask

   // sample on the falling edge, set seen here reaches the outputs 2 falling edges on
   always @(negedge clk) begin
      logic [8*sw-1:0] exp_set;
      logic            want;
      want = valid_hist[1];
      if (valid_o === 1'b1) begin
         if (expected_q.size() == 0) begin
            $display("%0t ns: valid_o went high with no input set waiting for it", $time);
            error_count++;
         end else begin
            if (!want) begin
               $display("%0t ns: valid_o came at the wrong cycle", $time);
               error_count++;
            end
            exp_set = expected_q.pop_front();
            compare_leg("y0", exp_set[8*sw-1 -: 2*sw], y0);
            compare_leg("y1", exp_set[6*sw-1 -: 2*sw], y1);
            compare_leg("y2", exp_set[4*sw-1 -: 2*sw], y2);
            compare_leg("y3", exp_set[2*sw-1:0], y3);
            check_count++;
         end
      end else if (want) begin
         $display("%0t ns: valid_o missing two cycles after valid_i", $time);
         error_count++;
         if (expected_q.size() > 0) begin
            exp_set = expected_q.pop_front();
         end
      end
      valid_hist = {valid_hist[0], (valid_i === 1'b1) && (rst === 1'b1)};
      if (valid_i === 1'b1) begin
         expected_q.push_back(expected_outputs(k, a0, a1, a2, a3));
      end
      outstanding = expected_q.size();
   end

endmodule

//--- verification/tb_radix4_butterfly.sv
`timescale 1ns/1ps

module tb_radix4_butterfly;

   localparam int clk_period   = 8;
   localparam int reset_cycles = 4;
   localparam int drive_skew   = 1;
   localparam int n_idle       = 8;
   localparam int n_sweep      = 64;
   localparam int n_gap        = 40;
   localparam int max_gap      = 3;
   // hand-picked and extreme sets are 6 and 8, each test drains in about 4 cycles
   localparam int total_vectors = reset_cycles + n_idle + 6 + n_sweep
                                  + n_gap * (max_gap + 1) + 8 + 5 * 4;
   localparam int timeout_ns = (total_vectors + 20) * clk_period;

   logic                    clk;
   logic                    rst;
   logic                    valid_i;
   fft_pkg::twiddle_index_t k;
   fft_pkg::cplx_t          a0, a1, a2, a3;
   fft_pkg::cplx_t          y0, y1, y2, y3;
   logic                    valid_o;
   int                      error_count;
   int                      check_count;
   int                      outstanding;
   int                      seed;
   int                      tests_run;
   int                      tests_clean;
   int                      errors_before;
   int                      sets_sent;
   int                      total_sent;
   int                      gap;

   clock_gen #(.period(clk_period), .reset_cycles(reset_cycles)) u_clock (
      .clk (clk),
      .rst (rst)
   );

   radix4_butterfly UUT (
      .clk (clk), .rst (rst), .valid_i (valid_i), .k (k),
      .a0 (a0), .a1 (a1), .a2 (a2), .a3 (a3),
      .y0 (y0), .y1 (y1), .y2 (y2), .y3 (y3), .valid_o (valid_o)
   );

   butterfly_checker u_checker (
      .clk (clk), .rst (rst), .valid_i (valid_i), .k (k),
      .a0 (a0), .a1 (a1), .a2 (a2), .a3 (a3),
      .y0 (y0), .y1 (y1), .y2 (y2), .y3 (y3), .valid_o (valid_o),
      .error_count (error_count), .check_count (check_count), .outstanding (outstanding)
   );

   function automatic fft_pkg::cplx_t complex_value(input int re, input int im);
      logic [10:0] re_bits;
      logic [10:0] im_bits;
      re_bits = re[10:0];
      im_bits = im[10:0];
      return {re_bits, im_bits};
   endfunction

   function fft_pkg::cplx_t random_sample();
      return fft_pkg::cplx_t'($random(seed));
   endfunction

   task automatic next_edge();
      @(posedge clk);
      #drive_skew;
   endtask

   task automatic send_set(input fft_pkg::twiddle_index_t kk, input fft_pkg::cplx_t x0,
                           input fft_pkg::cplx_t x1, input fft_pkg::cplx_t x2,
                           input fft_pkg::cplx_t x3);
      valid_i = 1'b1;
      k       = kk;
      a0      = x0;
      a1      = x1;
      a2      = x2;
      a3      = x3;
      sets_sent++;
      total_sent++;
      next_edge();
   endtask

   task automatic idle_cycles(input int n);
      valid_i = 1'b0;
      repeat (n) next_edge();
   endtask

   task automatic begin_test();
      errors_before = error_count;
      sets_sent     = 0;
   endtask

   task automatic end_test(input string name);
      int delta;
      valid_i = 1'b0;
      wait (outstanding == 0);
      next_edge();
      delta = error_count - errors_before;
      tests_run++;
      if (delta == 0) begin
         tests_clean++;
      end
      $display("test %0d %s: %0d sets, %0d errors", tests_run, name, sets_sent, delta);
   endtask

   initial begin
      valid_i     = 1'b0;
      k           = '0;
      a0          = '0;
      a1          = '0;
      a2          = '0;
      a3          = '0;
      seed        = 32'hc3d9_3104;
      tests_run   = 0;
      tests_clean = 0;
      total_sent  = 0;
      wait (rst === 1'b1);
      next_edge();

      begin_test();
      idle_cycles(n_idle);
      end_test("idle after reset");

      // unit twiddles, small values
      begin_test();
      send_set(0, complex_value(1, 0), complex_value(0, 0), complex_value(0, 0),
               complex_value(0, 0));
      send_set(0, complex_value(3, -2), complex_value(1, 1), complex_value(0, -1),
               complex_value(2, 0));
      send_set(0, complex_value(-5, 7), complex_value(4, -3), complex_value(2, 2),
               complex_value(-1, 0));
      send_set(0, complex_value(10, 0), complex_value(0, 10), complex_value(-10, 0),
               complex_value(0, -10));
      send_set(0, complex_value(100, -50), complex_value(-25, 75), complex_value(60, 30),
               complex_value(-8, -16));
      send_set(0, complex_value(-1, -1), complex_value(-1, -1), complex_value(-1, -1),
               complex_value(-1, -1));
      end_test("k zero hand-picked");

      begin_test();
      for (int i = 0; i < n_sweep; i++) begin
         send_set(i, random_sample(), random_sample(), random_sample(), random_sample());
      end
      end_test("k sweep back to back");

      begin_test();
      for (int i = 0; i < n_gap; i++) begin
         gap = {$random(seed)} % (max_gap + 1);
         idle_cycles(gap);
         send_set(fft_pkg::twiddle_index_t'($random(seed)), random_sample(),
                  random_sample(), random_sample(), random_sample());
      end
      end_test("random valid gaps");

      begin_test();
      send_set(0, complex_value(1023, 1023), complex_value(1023, 1023),
               complex_value(1023, 1023), complex_value(1023, 1023));
      send_set(0, complex_value(-1024, -1024), complex_value(-1024, -1024),
               complex_value(-1024, -1024), complex_value(-1024, -1024));
      send_set(8, complex_value(1023, -1024), complex_value(-1024, 1023),
               complex_value(1023, -1024), complex_value(-1024, 1023));
      send_set(16, complex_value(-1024, 1023), complex_value(1023, 1023),
               complex_value(1023, -1024), complex_value(-1024, -1024));
      send_set(21, complex_value(1023, 0), complex_value(0, 1023),
               complex_value(-1024, 0), complex_value(0, -1024));
      send_set(32, complex_value(-1024, -1024), complex_value(1023, 1023),
               complex_value(-1024, -1024), complex_value(1023, 1023));
      send_set(43, complex_value(1023, 1023), complex_value(-1024, -1024),
               complex_value(-1024, 1023), complex_value(1023, -1024));
      send_set(63, complex_value(-1023, 1023), complex_value(-1024, -1024),
               complex_value(1023, -1023), complex_value(-1024, 0));
      end_test("extreme values");

      if (check_count != total_sent) begin
         $display("only %0d of %0d input sets produced a result", check_count, total_sent);
      end
      $display("tests run %0d, clean %0d, sets checked %0d, errors %0d",
               tests_run, tests_clean, check_count, error_count);
      if (error_count == 0 && check_count == total_sent && tests_clean == tests_run) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // watchdog
   initial begin
      #(timeout_ns);
      $display("timeout after %0d ns, the run did not complete", timeout_ns);
      $display("tests failed");
      $finish;
   end

endmodule

//--- filelist.f
hdl/fft_pkg.sv
hdl/butterfly_core.sv
hdl/twiddle_rom.sv
hdl/twiddle_multiplier.sv
hdl/twiddle_stage.sv
hdl/radix4_butterfly.sv
verification/clock_gen.sv
verification/butterfly_checker.sv
verification/tb_radix4_butterfly.sv

//--- Bender.yml
package:
  name: radix4_butterfly

sources:
  - files:
      - hdl/fft_pkg.sv
      - hdl/butterfly_core.sv
      - hdl/twiddle_rom.sv
      - hdl/twiddle_multiplier.sv
      - hdl/twiddle_stage.sv
      - hdl/radix4_butterfly.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/butterfly_checker.sv
      - verification/tb_radix4_butterfly.sv
